// ==== vlog.f ====
icache_pkg.sv
icache_tag_array.sv
icache_data_array.sv
icache_refill_ctrl.sv
icache_top.sv
icache_props.sv
icache_tb.sv

// ==== Makefile ====
# Verilator flow for the icache testbench
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps --top-module icache_top -f vlog.f

obj_dir/Vicache_tb: vlog.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps --top-module icache_tb -f vlog.f

sim: obj_dir/Vicache_tb
	./obj_dir/Vicache_tb > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== icache_tb.sv ====
// icache testbench driving LFSR requests against a hashed bus memory and a line model
`default_nettype none

module icache_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import icache_pkg::*;

  localparam int NUM_REQ     = 400;
  localparam int CYCLE_LIMIT = NUM_REQ * 40;  // worst request stays far below 40

  logic            clk_i = 1'b0;
  logic            rst_ni;
  logic            req_i;
  logic [XLEN-1:0] adr_i;
  logic            flush_i;
  logic            ack_o;
  logic            err_o;
  logic [XLEN-1:0] q_o;
  logic            biu_stb_o;
  logic [XLEN-1:0] biu_adr_o;
  logic            biu_stb_ack_i;
  logic            biu_ack_i;
  logic [XLEN-1:0] biu_q_i;
  logic            biu_err_i;

  logic [15:0] lfsr_state;
  bit          filled [int unsigned];  // lines written since the last flush
  logic [27:0] last_line [16];         // newest fill per set is always resident
  bit          last_valid [16];
  int          cycle_cnt = 0;
  int          n_hit = 0;
  int          n_miss = 0;
  int          n_err = 0;

  icache_top u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .adr_i         (adr_i),
    .flush_i       (flush_i),
    .ack_o         (ack_o),
    .err_o         (err_o),
    .q_o           (q_o),
    .biu_stb_o     (biu_stb_o),
    .biu_adr_o     (biu_adr_o),
    .biu_stb_ack_i (biu_stb_ack_i),
    .biu_ack_i     (biu_ack_i),
    .biu_q_i       (biu_q_i),
    .biu_err_i     (biu_err_i)
  );

  always #10 clk_i = ~clk_i;  // 20 ns period

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      abort_run("timeout, the run did not end within the cycle limit");
    end
  end

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic compare_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
      abort_run("stopping at first mismatch");
    end
  endtask

  // galois lfsr x^16+x^14+x^13+x^11+1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  // bus memory word as a hash of the whole word address
  function automatic logic [31:0] mem_word(input logic [31:0] wadr);
    logic [31:0] h;
    h = wadr * 32'h9e37_79b1;
    return h ^ {h[15:0], h[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  // 8 tags x 16 sets x any word of the line
  function automatic logic [31:0] pick_addr();
    logic [TAG_BITS-1:0] tag;
    logic [3:0]          set;
    logic [1:0]          word;
    tag  = TAG_BITS'(32'h000c_3000 + rand_bits(3) * 32'h0a11);
    set  = 4'(rand_bits(4));
    word = 2'(rand_bits(2));
    return {tag, set, word, 2'b00};
  endfunction

  task automatic step_cycle();
    @(posedge clk_i);
    #1;                                     // drive point
  endtask

  task automatic pulse_flush();
    step_cycle();
    flush_i = 1'b1;
    step_cycle();
    flush_i = 1'b0;
  endtask

  // ------------------------------------------------------------------------
  // one request with the bus model answering a miss
  // ------------------------------------------------------------------------
  task automatic run_request(input logic [31:0] addr, input bit must_hit, input bit must_miss,
                             input bit inject_err, input int err_beat,
                             output bit hit, output bit fill_ok);
    logic [31:0] wadr;
    logic [1:0]  slot;
    int          gap;
    bit          ended;
    wadr    = {addr[31:2], 2'b00};
    fill_ok = 1'b0;
    ended   = 1'b0;
    step_cycle();
    req_i = 1'b1;
    adr_i = addr;
    step_cycle();
    req_i = 1'b0;
    @(negedge clk_i);                       // lookup result
    compare_val("err_o", err_o, 1'b0);
    compare_val("biu_stb_o", biu_stb_o, 1'b0);     // no strobe before the decision
    if (must_hit) compare_val("ack_o", ack_o, 1'b1);
    if (must_miss) compare_val("ack_o", ack_o, 1'b0);
    hit = ack_o;
    if (hit) begin
      compare_val("q_o", q_o, mem_word(wadr));
      step_cycle();
      @(negedge clk_i);
      compare_val("biu_stb_o", biu_stb_o, 1'b0);   // hit stays off the bus
      compare_val("ack_o", ack_o, 1'b0);
    end else begin
      step_cycle();
      @(negedge clk_i);
      compare_val("biu_stb_o", biu_stb_o, 1'b1);   // two cycles after req
      compare_val("biu_adr_o", biu_adr_o, wadr);
      gap = int'(rand_bits(2));
      repeat (gap) begin
        step_cycle();
        @(negedge clk_i);
        compare_val("biu_stb_o", biu_stb_o, 1'b1);
      end
      step_cycle();
      biu_stb_ack_i = 1'b1;
      @(negedge clk_i);
      compare_val("biu_stb_o", biu_stb_o, 1'b1);
      for (int b = 0; b < BURST_LEN && !ended; b++) begin
        gap = int'(rand_bits(2));
        repeat (gap) begin
          step_cycle();
          biu_stb_ack_i = 1'b0;
          biu_ack_i     = 1'b0;
          @(negedge clk_i);
          compare_val("biu_stb_o", biu_stb_o, 1'b0);
          compare_val("ack_o", ack_o, 1'b0);
        end
        step_cycle();
        slot          = wadr[3:2] + 2'(b);  // wraps inside the line
        biu_stb_ack_i = 1'b0;
        biu_ack_i     = 1'b1;
        biu_q_i       = mem_word({wadr[31:4], slot, 2'b00});
        biu_err_i     = inject_err && (b == err_beat);
        @(negedge clk_i);
        compare_val("biu_stb_o", biu_stb_o, 1'b0);
        compare_val("err_o", err_o, biu_err_i);
        compare_val("ack_o", ack_o, !biu_err_i && b == 0);
        if (b == 0 && !biu_err_i) compare_val("q_o", q_o, mem_word(wadr));
        ended = biu_err_i;
      end
      step_cycle();                         // recover cycle
      biu_ack_i = 1'b0;
      biu_err_i = 1'b0;
      @(negedge clk_i);
      compare_val("biu_stb_o", biu_stb_o, 1'b0);
      compare_val("ack_o", ack_o, 1'b0);
      compare_val("err_o", err_o, 1'b0);
      fill_ok = !inject_err;
    end
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------
  initial begin
    logic [31:0] addr;
    logic [31:0] prev_addr;
    bit          prev_ok;
    bit          retry;
    bit          rep;
    bit          flushed;
    bit          must_hit;
    bit          must_miss;
    bit          inject;
    int          err_beat;
    bit          hit;
    bit          ok;
    int unsigned line;
    int          set;
    rst_ni        = 1'b0;
    req_i         = 1'b0;
    adr_i         = '0;
    flush_i       = 1'b0;
    biu_stb_ack_i = 1'b0;
    biu_ack_i     = 1'b0;
    biu_q_i       = '0;
    biu_err_i     = 1'b0;
    lfsr_state    = 16'd45;
    prev_addr     = '0;
    prev_ok       = 1'b0;
    retry         = 1'b0;
    for (int s = 0; s < 16; s++) last_valid[s] = 1'b0;
    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(negedge clk_i);
    compare_val("ack_o", ack_o, 1'b0);
    compare_val("err_o", err_o, 1'b0);
    compare_val("biu_stb_o", biu_stb_o, 1'b0);

    for (int n = 0; n < NUM_REQ; n++) begin
      rep     = !retry && prev_ok && (rand_bits(2) == 0);  // repeat right after its fill
      addr    = (retry || rep) ? prev_addr : pick_addr();
      flushed = !retry && (rand_bits(4) == 0);
      if (flushed) begin
        pulse_flush();
        filled.delete();
        for (int s = 0; s < 16; s++) last_valid[s] = 1'b0;
      end
      line      = addr[31:4];
      set       = int'(addr[7:4]);
      // never filled or its fill just failed
      must_miss = !filled.exists(line) || retry;
      must_hit  = (last_valid[set] && last_line[set] == addr[31:4]) || (rep && !flushed);
      inject    = (rand_bits(3) == 0);
      err_beat  = int'(rand_bits(2));
      run_request(addr, must_hit, must_miss, inject, err_beat, hit, ok);
      if (hit) n_hit++;
      else n_miss++;
      if (!hit && inject) n_err++;
      if (ok) begin
        filled[line]   = 1'b1;
        last_line[set] = addr[31:4];
        last_valid[set] = 1'b1;
      end
      retry     = !hit && inject;           // aborted fill left nothing behind
      prev_addr = addr;
      prev_ok   = hit || ok;
    end

    step_cycle();
    if (n_hit == 0 || n_miss == 0 || n_err == 0) begin
      abort_run("the run saw no hit, no miss or no error response");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== icache_props.sv ====
// icache props: bus strobe and core response checks bound into the refill controller
`default_nettype none

module icache_props (
  input logic clk_i,
  input logic rst_ni,
  input logic req_i,
  input logic ack_i,      // core ack
  input logic err_i,      // core err
  input logic stb_i,      // bus strobe
  input logic stb_ack_i
);
  timeunit 1ns;
  timeprecision 100ps;

  logic open_q;           // request taken, no ack or err yet

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      open_q <= 1'b0;
    end else if (req_i) begin
      open_q <= 1'b1;
    end else if (ack_i || err_i) begin
      open_q <= 1'b0;
    end
  end

  // ------------------------------------------------------------------------
  // bus strobe
  // ------------------------------------------------------------------------
  stb_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stb_i && !stb_ack_i |=> stb_i)
    else $error("biu_stb_o dropped before biu_stb_ack_i");

  stb_drop_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stb_i && stb_ack_i |=> !stb_i)
    else $error("biu_stb_o still high after biu_stb_ack_i");

  // ------------------------------------------------------------------------
  // core response
  // ------------------------------------------------------------------------
  ack_err_a: assert property (@(posedge clk_i) disable iff (!rst_ni) !(ack_i && err_i))
    else $error("ack_o and err_o high in the same cycle");

  ack_req_a: assert property (@(posedge clk_i) disable iff (!rst_ni) ack_i |-> open_q)
    else $error("ack_o without an open request");

endmodule

// one checker per controller
bind icache_refill_ctrl icache_props u_props (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .req_i     (req_i),
  .ack_i     (ack_o),
  .err_i     (err_o),
  .stb_i     (biu_stb_o),
  .stb_ack_i (biu_stb_ack_i)
);

`default_nettype wire

// ==== icache_top.sv ====
// icache top: tag array and data array read side by side, refill controller on top
`default_nettype none

module icache_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // core
  input  logic                      req_i,
  input  logic [icache_pkg::XLEN-1:0] adr_i,
  input  logic                      flush_i,
  output logic                      ack_o,
  output logic                      err_o,
  output logic [icache_pkg::XLEN-1:0] q_o,
  // bus
  output logic                      biu_stb_o,
  output logic [icache_pkg::XLEN-1:0] biu_adr_o,
  input  logic                      biu_stb_ack_i,
  input  logic                      biu_ack_i,
  input  logic [icache_pkg::XLEN-1:0] biu_q_i,
  input  logic                      biu_err_i
);
  import icache_pkg::*;

  // lookup path
  logic [IDX_BITS-1:0] lookup_idx;
  logic [TAG_BITS-1:0] lookup_tag;
  logic [WAYS-1:0]     way_hit;
  logic [BLK_BITS-1:0] line_q;

  // fill path
  logic                fill_we;
  logic [IDX_BITS-1:0] fill_idx;
  logic [TAG_BITS-1:0] fill_tag;
  logic [WAYS-1:0]     fill_way;
  logic [BLK_BITS-1:0] fill_line;
  logic [WAYS-1:0]     victim_way;
  logic                lfsr_hold;

  // ------------------------------------------------------------------------
  // arrays
  // ------------------------------------------------------------------------
  icache_tag_array u_tag (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .lookup_idx_i (lookup_idx),
    .lookup_tag_i (lookup_tag),
    .fill_we_i    (fill_we),
    .fill_idx_i   (fill_idx),
    .fill_tag_i   (fill_tag),
    .lfsr_hold_i  (lfsr_hold),
    .way_hit_o    (way_hit),
    .victim_way_o (victim_way)
  );

  icache_data_array u_data (
    .clk_i        (clk_i),
    .lookup_idx_i (lookup_idx),
    .way_hit_i    (way_hit),
    .fill_we_i    (fill_we),
    .fill_idx_i   (fill_idx),
    .fill_way_i   (fill_way),
    .fill_line_i  (fill_line),
    .line_q_o     (line_q)
  );

  // ------------------------------------------------------------------------
  // controller
  // ------------------------------------------------------------------------
  icache_refill_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .adr_i         (adr_i),
    .ack_o         (ack_o),
    .err_o         (err_o),
    .q_o           (q_o),
    .way_hit_i     (way_hit),
    .line_q_i      (line_q),
    .victim_way_i  (victim_way),
    .lookup_idx_o  (lookup_idx),
    .lookup_tag_o  (lookup_tag),
    .lfsr_hold_o   (lfsr_hold),
    .fill_we_o     (fill_we),
    .fill_idx_o    (fill_idx),
    .fill_tag_o    (fill_tag),
    .fill_way_o    (fill_way),
    .fill_line_o   (fill_line),
    .biu_stb_o     (biu_stb_o),
    .biu_adr_o     (biu_adr_o),
    .biu_stb_ack_i (biu_stb_ack_i),
    .biu_ack_i     (biu_ack_i),
    .biu_q_i       (biu_q_i),
    .biu_err_i     (biu_err_i)
  );

endmodule

`default_nettype wire

// ==== icache_refill_ctrl.sv ====
// icache refill controller with lookup and bus FSMs, wrapping burst refill and core response
`default_nettype none

module icache_refill_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // core
  input  logic                          req_i,
  input  logic [icache_pkg::XLEN-1:0]     adr_i,
  output logic                          ack_o,
  output logic                          err_o,
  output logic [icache_pkg::XLEN-1:0]     q_o,
  // arrays
  input  logic [icache_pkg::WAYS-1:0]     way_hit_i,
  input  logic [icache_pkg::BLK_BITS-1:0] line_q_i,
  input  logic [icache_pkg::WAYS-1:0]     victim_way_i,
  output logic [icache_pkg::IDX_BITS-1:0] lookup_idx_o,
  output logic [icache_pkg::TAG_BITS-1:0] lookup_tag_o,
  output logic                          lfsr_hold_o,
  output logic                          fill_we_o,
  output logic [icache_pkg::IDX_BITS-1:0] fill_idx_o,
  output logic [icache_pkg::TAG_BITS-1:0] fill_tag_o,
  output logic [icache_pkg::WAYS-1:0]     fill_way_o,
  output logic [icache_pkg::BLK_BITS-1:0] fill_line_o,
  // bus
  output logic                          biu_stb_o,
  output logic [icache_pkg::XLEN-1:0]     biu_adr_o,
  input  logic                          biu_stb_ack_i,
  input  logic                          biu_ack_i,
  input  logic [icache_pkg::XLEN-1:0]     biu_q_i,
  input  logic                          biu_err_i
);
  import icache_pkg::*;

  lookup_state_e lk_state_q;
  bus_state_e    bus_state_q;

  // request side
  logic                           pend_q;       // request waiting for ack or err
  logic [XLEN-1:WORD_LSB]         adr_q;        // word address of that request
  logic [BURST_LEN-1:0][XLEN-1:0] hit_line;

  // refill side
  logic [XLEN-1:WORD_LSB]         fill_wadr_q;  // missed word address held for the fill
  logic [BEAT_BITS-1:0]           beat_cnt_q;
  logic [BEAT_BITS-1:0]           wptr_q;       // wrapping word slot of the next beat
  logic [BURST_LEN-1:0][XLEN-1:0] line_buf_q;
  logic [BURST_LEN-1:0][XLEN-1:0] line_asm;

  logic lookup_hit;
  logic miss;
  logic beat;
  logic first_beat;
  logic last_beat;
  logic bus_err;
  logic burst_end;

  // ------------------------------------------------------------------------
  // request capture and lookup
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= 1'b0;
    end else if (req_i) begin
      pend_q <= 1'b1;
    end else if (ack_o || err_o) begin
      pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) adr_q <= adr_i[XLEN-1:WORD_LSB];
  end

  // a new request reads straight away and the held one is read otherwise
  // (RECOVER relies on this to see the freshly filled line)
  assign lookup_idx_o = req_i ? adr_i[BLK_OFF_BITS +: IDX_BITS]
                              : adr_q[BLK_OFF_BITS +: IDX_BITS];
  assign lookup_tag_o = adr_q[XLEN-1 -: TAG_BITS];  // compared a cycle later

  // hit or miss is only decided in ARMED
  assign lookup_hit = (lk_state_q == ARMED) & pend_q &  (|way_hit_i);
  assign miss       = (lk_state_q == ARMED) & pend_q & ~(|way_hit_i);

  // ------------------------------------------------------------------------
  // lookup FSM
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lk_state_q <= ARMED;
    end else begin
      case (lk_state_q)
        ARMED:   if (miss) lk_state_q <= FILL;
        FILL:    if (burst_end) lk_state_q <= RECOVER;
        RECOVER: lk_state_q <= ARMED;       // arrays were written last cycle so re-read
        default: lk_state_q <= ARMED;
      endcase
    end
  end

  // victim stays put from the miss cycle up to the tag write
  assign lfsr_hold_o = (lk_state_q == FILL) | miss;

  // ------------------------------------------------------------------------
  // bus FSM
  // ------------------------------------------------------------------------
  assign beat       = (bus_state_q == BURST) & biu_ack_i & ~biu_err_i;
  assign bus_err    = (bus_state_q == BURST) & biu_err_i;
  assign first_beat = (beat_cnt_q == '0);   // carries the requested word
  assign last_beat  = beat & (beat_cnt_q == BEAT_BITS'(BURST_LEN - 1));
  assign burst_end  = last_beat | bus_err;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_state_q <= BUS_IDLE;
    end else begin
      case (bus_state_q)
        BUS_IDLE: if (miss) bus_state_q <= WAIT4BIU;
        WAIT4BIU: if (biu_stb_ack_i) bus_state_q <= BURST;
        BURST:    if (burst_end) bus_state_q <= BUS_IDLE;
        default:  bus_state_q <= BUS_IDLE;
      endcase
    end
  end

  // beat counter and wrapping word pointer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q <= '0;
      wptr_q     <= '0;
    end else if (miss) begin
      beat_cnt_q <= '0;
      wptr_q     <= adr_q[BLK_OFF_BITS-1:WORD_LSB];   // start at missed word
    end else if (beat) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
      wptr_q     <= wptr_q + 1'b1;                    // wraps inside the line
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss) fill_wadr_q <= adr_q;
    if (beat) line_buf_q[wptr_q] <= biu_q_i;
  end

  assign biu_stb_o = (bus_state_q == WAIT4BIU);
  assign biu_adr_o = {fill_wadr_q, {WORD_LSB{1'b0}}};

  // ------------------------------------------------------------------------
  // fill write
  // ------------------------------------------------------------------------
  // last beat goes straight into the line and skips the buffer
  always_comb begin
    line_asm         = line_buf_q;
    line_asm[wptr_q] = biu_q_i;
  end

  assign fill_we_o   = last_beat;
  assign fill_idx_o  = fill_wadr_q[BLK_OFF_BITS +: IDX_BITS];
  assign fill_tag_o  = fill_wadr_q[XLEN-1 -: TAG_BITS];
  assign fill_way_o  = victim_way_i;
  assign fill_line_o = line_asm;

  // ------------------------------------------------------------------------
  // core response
  // ------------------------------------------------------------------------
  assign hit_line = line_q_i;

  assign ack_o = lookup_hit | (beat & first_beat);
  assign err_o = bus_err;                   // any error beat is reported
  assign q_o   = (bus_state_q == BURST) ? biu_q_i
                                        : hit_line[adr_q[BLK_OFF_BITS-1:WORD_LSB]];

endmodule

`default_nettype wire

// ==== icache_data_array.sv ====
// icache data array: per-way line storage with a hit-way select on the read side
`default_nettype none

module icache_data_array (
  input  logic                          clk_i,
  input  logic [icache_pkg::IDX_BITS-1:0] lookup_idx_i,
  input  logic [icache_pkg::WAYS-1:0]     way_hit_i,    // same cycle as the read data
  input  logic                          fill_we_i,
  input  logic [icache_pkg::IDX_BITS-1:0] fill_idx_i,
  input  logic [icache_pkg::WAYS-1:0]     fill_way_i,   // one-hot
  input  logic [icache_pkg::BLK_BITS-1:0] fill_line_i,
  output logic [icache_pkg::BLK_BITS-1:0] line_q_o
);
  import icache_pkg::*;

  logic [BLK_BITS-1:0] line_mem  [WAYS][SETS];
  logic [BLK_BITS-1:0] line_rd_q [WAYS];

  // ------------------------------------------------------------------------
  // line RAMs
  // ------------------------------------------------------------------------
  for (genvar w = 0; w < WAYS; w++) begin : gen_way
    // whole-line write, synchronous read
    always_ff @(posedge clk_i) begin
      if (fill_we_i && fill_way_i[w]) begin
        line_mem[w][fill_idx_i] <= fill_line_i;
      end
      line_rd_q[w] <= line_mem[w][lookup_idx_i];
    end
  end

  // ------------------------------------------------------------------------
  // hit-way select
  // ------------------------------------------------------------------------
  // and-or mux, way_hit is one-hot or zero
  always_comb begin
    line_q_o = '0;
    for (int w = 0; w < WAYS; w++) begin
      line_q_o = line_q_o | (line_rd_q[w] & {BLK_BITS{way_hit_i[w]}});
    end
  end

endmodule

`default_nettype wire

// ==== icache_tag_array.sv ====
// icache tag array: per-way tags and valid bits, hit compare, LFSR victim choice
`default_nettype none

module icache_tag_array (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,       // clears every valid bit
  input  logic [icache_pkg::IDX_BITS-1:0] lookup_idx_i,
  input  logic [icache_pkg::TAG_BITS-1:0] lookup_tag_i,  // one cycle after idx
  input  logic                          fill_we_i,
  input  logic [icache_pkg::IDX_BITS-1:0] fill_idx_i,
  input  logic [icache_pkg::TAG_BITS-1:0] fill_tag_i,
  input  logic                          lfsr_hold_i,   // freeze victim while filling
  output logic [icache_pkg::WAYS-1:0]     way_hit_o,
  output logic [icache_pkg::WAYS-1:0]     victim_way_o   // one-hot
);
  import icache_pkg::*;

  logic [TAG_BITS-1:0]  tag_mem  [WAYS][SETS];
  logic [SETS-1:0]      valid_q  [WAYS];
  logic [TAG_BITS-1:0]  tag_rd_q [WAYS];       // registered tag read
  logic                 vld_rd_q [WAYS];       // registered valid read
  logic [LFSR_BITS-1:0] lfsr_q;

  // ------------------------------------------------------------------------
  // storage and compare, one slice per way
  // ------------------------------------------------------------------------
  for (genvar w = 0; w < WAYS; w++) begin : gen_way

    // tag RAM, read first
    always_ff @(posedge clk_i) begin
      if (fill_we_i && victim_way_o[w]) begin
        tag_mem[w][fill_idx_i] <= fill_tag_i;
      end
      tag_rd_q[w] <= tag_mem[w][lookup_idx_i];
    end

    // valid bits live in flops so a flush hits all sets at once
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q[w] <= '0;
      end else if (flush_i) begin
        valid_q[w] <= '0;
      end else if (fill_we_i && victim_way_o[w]) begin
        valid_q[w][fill_idx_i] <= 1'b1;
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        vld_rd_q[w] <= 1'b0;
      end else if (flush_i) begin
        vld_rd_q[w] <= 1'b0;                  // no stale hit right after flush
      end else begin
        vld_rd_q[w] <= valid_q[w][lookup_idx_i];
      end
    end

    assign way_hit_o[w] = vld_rd_q[w] & (tag_rd_q[w] == lookup_tag_i);
  end

  // ------------------------------------------------------------------------
  // pseudo-random victim
  // ------------------------------------------------------------------------
  // xnor feedback, all-zero reset state is legal
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= '0;
    end else if (!lfsr_hold_i) begin
      lfsr_q <= {lfsr_q[LFSR_BITS-2:0], lfsr_q[LFSR_BITS-1] ~^ lfsr_q[LFSR_BITS-4]};
    end
  end

  assign victim_way_o = WAYS'(1) << lfsr_q[WAY_BITS-1:0]; // low bits pick the way

endmodule

`default_nettype wire

// ==== icache_pkg.sv ====
// icache package: cache geometry, address field widths and FSM state types
`default_nettype none

package icache_pkg;

  // ------------------------------------------------------------------------
  // geometry
  // ------------------------------------------------------------------------
  localparam int XLEN        = 32;              // data and address width
  localparam int BLOCK_BYTES = 16;              // bytes per line
  localparam int WAYS        = 2;
  localparam int SETS        = 16;              // sets per way

  // address fields, tag | index | word | byte
  localparam int BLK_OFF_BITS = $clog2(BLOCK_BYTES);
  localparam int IDX_BITS     = $clog2(SETS);
  localparam int TAG_BITS     = XLEN - IDX_BITS - BLK_OFF_BITS;
  localparam int WORD_LSB     = $clog2(XLEN / 8); // byte bits inside a word

  // line and burst
  localparam int BLK_BITS  = 8 * BLOCK_BYTES;   // bits per line
  localparam int BURST_LEN = BLK_BITS / XLEN;   // beats per refill
  localparam int BEAT_BITS = $clog2(BURST_LEN); // beat counter, word offset

  // victim selection
  localparam int WAY_BITS  = $clog2(WAYS);
  localparam int LFSR_BITS = 20;                // taps at 20 and 17

  // ------------------------------------------------------------------------
  // state types
  // ------------------------------------------------------------------------

  // core side: ARMED looks up, FILL waits on the bus, RECOVER re-reads
  typedef enum logic [1:0] {
    ARMED,
    FILL,
    RECOVER
  } lookup_state_e;

  // bus side
  typedef enum logic [1:0] {
    BUS_IDLE,
    WAIT4BIU,   // strobe out, waiting for stb_ack
    BURST       // counting beats
  } bus_state_e;

endpackage

`default_nettype wire
